//--- build.f
+incdir+.
ddr3_odt_timing_pkg.sv
ddr3_odt_cmd_pkg.sv
ddr3_odt_read_align.sv
ddr3_odt_window_counter.sv
ddr3_odt_phase_gen.sv
ddr3_odt_gen.sv
ddr3_odt_properties.sv
tb_ddr3_odt_gen.sv

//--- Makefile
TOP := tb_ddr3_odt_gen

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f build.f
	verilator --lint-only --top-module ddr3_odt_gen -f build.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) +verilator+error+limit+1000 > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb_ddr3_odt_gen.sv
// needs --timing and --assert; commands are 10 cycles apart so windows never overlap
`timescale 1ns/100ps
`default_nettype none

module tb_ddr3_odt_gen;

    localparam int NUM_TESTS     = 14;
    localparam int CMDS_PER_TEST = 8;
    localparam int CYCLE_LIMIT   = NUM_TESTS * CMDS_PER_TEST * 10 + 100;
    localparam int BASE_CWL      = 5;

    logic                            ctl_clk;
    logic                            ctl_reset_n;
    ddr3_odt_timing_pkg::lat_t       cfg_tcl;
    ddr3_odt_timing_pkg::lat_t       cfg_cas_wr_lat;
    ddr3_odt_timing_pkg::out_stage_t cfg_output_regd;
    logic                            bg_do_write;
    logic                            bg_do_read;
    logic                            bg_do_burst_chop;
    logic                            odt_h;
    logic                            odt_l;

    logic [7:0] lfsr_q = 8'd54;
    int         cycle_count = 0;
    int         local_errors = 0;
    int         tests_done = 0;
    int         errors_at_start = 0;

    ddr3_odt_gen dut_i (
        .ctl_clk          (ctl_clk),
        .ctl_reset_n      (ctl_reset_n),
        .cfg_tcl          (cfg_tcl),
        .cfg_cas_wr_lat   (cfg_cas_wr_lat),
        .cfg_output_regd  (cfg_output_regd),
        .bg_do_write      (bg_do_write),
        .bg_do_read       (bg_do_read),
        .bg_do_burst_chop (bg_do_burst_chop),
        .odt_h            (odt_h),
        .odt_l            (odt_l)
    );

    bind ddr3_odt_gen ddr3_odt_properties props_i (
        .ctl_clk          (ctl_clk),
        .ctl_reset_n      (ctl_reset_n),
        .cfg_tcl          (cfg_tcl),
        .cfg_cas_wr_lat   (cfg_cas_wr_lat),
        .cfg_output_regd  (cfg_output_regd),
        .bg_do_write      (bg_do_write),
        .bg_do_read       (bg_do_read),
        .bg_do_burst_chop (bg_do_burst_chop),
        .odt_h            (odt_h),
        .odt_l            (odt_l)
    );

    initial
    begin
        ctl_clk = 1'b0;
    end

    always #4 ctl_clk = ~ctl_clk;

    always @(posedge ctl_clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_next(input logic [7:0] state);
        return {state[6:0], state[7] ^ state[5] ^ state[4] ^ state[3]};
    endfunction

    task automatic take_bits(input int count, output logic [7:0] value);
        value = 8'd0;
        for (int i = 0; i < count; i++)
        begin
            lfsr_q = lfsr_next(lfsr_q);
            value  = {value[6:0], lfsr_q[0]};
        end
    endtask

    function automatic int error_total();
        return local_errors + dut_i.props_i.fail_total;
    endfunction

    task automatic check_idle_low();
        if (odt_h !== 1'b0)
        begin
            $display("[FAIL] t=%0t odt_h got %b expected %b", $time, odt_h, 1'b0);
            local_errors++;
        end
        if (odt_l !== 1'b0)
        begin
            $display("[FAIL] t=%0t odt_l got %b expected %b", $time, odt_l, 1'b0);
            local_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        int new_errors;
        check_idle_low();
        new_errors      = error_total() - errors_at_start;
        errors_at_start = error_total();
        tests_done++;
        $display("test %0s: %0d error(s)", name, new_errors);
    endtask

    // six idle cycles let the registered latency gap settle
    task automatic apply_config(input ddr3_odt_timing_pkg::out_stage_t stage, input int gap);
        @(posedge ctl_clk);
        #1;
        cfg_cas_wr_lat  = ddr3_odt_timing_pkg::lat_t'(BASE_CWL);
        cfg_tcl         = ddr3_odt_timing_pkg::lat_t'(BASE_CWL + gap);
        cfg_output_regd = stage;
        repeat (6) @(posedge ctl_clk);
    endtask

    task automatic issue_command(input logic is_read);
        logic [7:0] chop_bits;
        take_bits(1, chop_bits);
        @(posedge ctl_clk);
        #1;
        bg_do_write      = !is_read;
        bg_do_read       = is_read;
        bg_do_burst_chop = chop_bits[0];
        @(posedge ctl_clk);
        #1;
        bg_do_write      = 1'b0;
        bg_do_read       = 1'b0;
        bg_do_burst_chop = 1'b0;
        repeat (8) @(posedge ctl_clk);
    endtask

    task automatic run_commands(input ddr3_odt_timing_pkg::out_stage_t stage,
                                input logic is_read, input int gap, input string name);
        apply_config(stage, gap);
        repeat (CMDS_PER_TEST) issue_command(is_read);
        #1;
        finish_test(name);
    endtask

    initial
    begin
        logic [7:0]                      pick;
        ddr3_odt_timing_pkg::out_stage_t stage;
        ctl_reset_n      = 1'b0;
        cfg_tcl          = ddr3_odt_timing_pkg::lat_t'(BASE_CWL);
        cfg_cas_wr_lat   = ddr3_odt_timing_pkg::lat_t'(BASE_CWL);
        cfg_output_regd  = ddr3_odt_timing_pkg::OUT_DIRECT;
        bg_do_write      = 1'b0;
        bg_do_read       = 1'b0;
        bg_do_burst_chop = 1'b0;

        repeat (8) @(posedge ctl_clk);
        #1;
        check_idle_low();
        ctl_reset_n = 1'b1;
        repeat (2) @(posedge ctl_clk);
        #1;
        finish_test("reset_idle");

        run_commands(ddr3_odt_timing_pkg::OUT_DIRECT, 1'b0, 0, "write_direct");
        for (int gap = 0; gap < 6; gap++)
        begin
            run_commands(ddr3_odt_timing_pkg::OUT_DIRECT, 1'b1, gap,
                         $sformatf("read_gap%0d_direct", gap));
        end

        // register stages, with one even and one odd random gap each
        for (int s = 1; s <= 2; s++)
        begin
            stage = ddr3_odt_timing_pkg::out_stage_t'(s);
            run_commands(stage, 1'b0, 0, $sformatf("write_reg%0d", s));
            take_bits(3, pick);
            run_commands(stage, 1'b1, 2 * (int'(pick) % 3),
                         $sformatf("read_even_reg%0d", s));
            take_bits(3, pick);
            run_commands(stage, 1'b1, 2 * (int'(pick) % 3) + 1,
                         $sformatf("read_odd_reg%0d", s));
        end

        $display("summary: %0d tests, %0d assertion failures, %0d idle errors",
                 tests_done, dut_i.props_i.fail_total, local_errors);
        if (error_total() == 0)
        begin
            $display("Done: no errors");
        end
        else
        begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- ddr3_odt_properties.sv
// expected windows come from the port rules only; assumes quasi-static config and no overlap
`timescale 1ns/100ps
`default_nettype none

`include "ddr3_odt_cfg.svh"

module ddr3_odt_properties
(
    input wire                                  ctl_clk,
    input wire                                  ctl_reset_n,
    input wire ddr3_odt_timing_pkg::lat_t       cfg_tcl,
    input wire ddr3_odt_timing_pkg::lat_t       cfg_cas_wr_lat,
    input wire ddr3_odt_timing_pkg::out_stage_t cfg_output_regd,
    input wire                                  bg_do_write,
    input wire                                  bg_do_read,
    input wire                                  bg_do_burst_chop,
    input wire                                  odt_h,
    input wire                                  odt_l
);

    // window length in controller clocks, two memory clocks each
    localparam int LEN_BL8 = `ODT_HOLD_BL8 / (`ODT_DWIDTH_RATIO / 2);
    localparam int LEN_BC4 = `ODT_HOLD_BC4 / (`ODT_DWIDTH_RATIO / 2);

    int          fail_reset = 0;
    int          fail_h = 0;
    int          fail_l = 0;
    int          fail_run = 0;
    int          fail_total;
    int          gap;
    int          delay;
    int          stage;
    int          len;
    int          h_off;
    int          l_off;
    int          run_h;
    logic [15:0] win;
    logic [15:0] cmd_h;
    logic [15:0] cmd_l;
    logic [15:0] pend_h;
    logic [15:0] pend_l;
    logic        exp_h;
    logic        exp_l;

    assign fail_total = fail_reset + fail_h + fail_l + fail_run;

    always_comb
    begin
        gap   = int'(cfg_tcl) - int'(cfg_cas_wr_lat);
        // reads wait gap/2 rounded up, none at all below one controller clock
        delay = (gap < 2) ? 0 : (gap + 1) / 2;
        len   = bg_do_burst_chop ? LEN_BC4 : LEN_BL8;
        case (cfg_output_regd)
            ddr3_odt_timing_pkg::OUT_REG1: stage = 1;
            ddr3_odt_timing_pkg::OUT_REG2: stage = 2;
            default:                       stage = 0;
        endcase
        if (bg_do_read && gap[0])
        begin
            // odd gap: both phases share the later waveform
            h_off = delay + 1 + stage;
            l_off = h_off;
        end
        else if (bg_do_read)
        begin
            h_off = delay + stage;
            l_off = h_off + 1;
        end
        else
        begin
            h_off = stage;
            l_off = stage + 1;
        end
        win   = (16'd1 << len) - 16'd1;
        cmd_h = (bg_do_write || bg_do_read) ? (win << h_off) : 16'd0;
        cmd_l = (bg_do_write || bg_do_read) ? (win << l_off) : 16'd0;
        exp_h = pend_h[0] | cmd_h[0];
        exp_l = pend_l[0] | cmd_l[0];
    end

    // bit k of each vector is the expected level k cycles ahead
    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            pend_h <= '0;
            pend_l <= '0;
            run_h  <= 0;
        end
        else
        begin
            pend_h <= (pend_h | cmd_h) >> 1;
            pend_l <= (pend_l | cmd_l) >> 1;
            if (!odt_h)
            begin
                run_h <= 0;
            end
            else if (run_h < 15)
            begin
                run_h <= run_h + 1;
            end
        end
    end

    a_reset_quiet: assert property (@(posedge ctl_clk)
        !ctl_reset_n |-> (!odt_h && !odt_l))
    else
    begin
        fail_reset++;
        $error("ODT output is high while reset is asserted");
    end

    a_odt_h_window: assert property (@(posedge ctl_clk) disable iff (!ctl_reset_n)
        odt_h == exp_h)
    else
    begin
        fail_h++;
        $error("[FAIL] t=%0t odt_h got %b expected %b", $time, $sampled(odt_h),
               $sampled(exp_h));
    end

    a_odt_l_window: assert property (@(posedge ctl_clk) disable iff (!ctl_reset_n)
        odt_l == exp_l)
    else
    begin
        fail_l++;
        $error("[FAIL] t=%0t odt_l got %b expected %b", $time, $sampled(odt_l),
               $sampled(exp_l));
    end

    // no window is ever longer than a full BL8 one
    a_odt_h_length: assert property (@(posedge ctl_clk) disable iff (!ctl_reset_n)
        odt_h |-> (run_h < LEN_BL8))
    else
    begin
        fail_run++;
        $error("odt_h stayed high longer than a BL8 window");
    end

endmodule

`default_nettype wire

//--- ddr3_odt_gen.sv
// half rate only; configuration is quasi-static and commands must not open overlapping windows
`timescale 1ns/100ps
`default_nettype none

module ddr3_odt_gen
(
    input  wire                                  ctl_clk,
    input  wire                                  ctl_reset_n,
    input  wire ddr3_odt_timing_pkg::lat_t       cfg_tcl,
    input  wire ddr3_odt_timing_pkg::lat_t       cfg_cas_wr_lat,
    input  wire ddr3_odt_timing_pkg::out_stage_t cfg_output_regd,
    input  wire                                  bg_do_write,
    input  wire                                  bg_do_read,
    input  wire                                  bg_do_burst_chop,
    output logic                                 odt_h,
    output logic                                 odt_l
);

    logic                     read_start;
    ddr3_odt_cmd_pkg::burst_t read_chop;
    logic                     diff_odd;
    logic                     write_active;
    logic                     read_active;

    // reads are shifted by tcl - cwl since ODT latency follows cwl
    ddr3_odt_read_align read_align_i (
        .ctl_clk          (ctl_clk),
        .ctl_reset_n      (ctl_reset_n),
        .cfg_tcl          (cfg_tcl),
        .cfg_cas_wr_lat   (cfg_cas_wr_lat),
        .bg_do_read       (bg_do_read),
        .bg_do_burst_chop (bg_do_burst_chop),
        .read_start       (read_start),
        .read_chop        (read_chop),
        .diff_odd         (diff_odd)
    );

    ddr3_odt_window_counter wr_win_i (
        .ctl_clk     (ctl_clk),
        .ctl_reset_n (ctl_reset_n),
        .start       (bg_do_write),
        .chop        (ddr3_odt_cmd_pkg::burst_t'(bg_do_burst_chop)),
        .active      (write_active)
    );

    ddr3_odt_window_counter rd_win_i (
        .ctl_clk     (ctl_clk),
        .ctl_reset_n (ctl_reset_n),
        .start       (read_start),
        .chop        (read_chop),
        .active      (read_active)
    );

    ddr3_odt_phase_gen phase_gen_i (
        .ctl_clk         (ctl_clk),
        .ctl_reset_n     (ctl_reset_n),
        .cfg_output_regd (cfg_output_regd),
        .write_start     (bg_do_write),
        .read_start      (read_start),
        .write_active    (write_active),
        .read_active     (read_active),
        .diff_odd        (diff_odd),
        .odt_h           (odt_h),
        .odt_l           (odt_l)
    );

endmodule

`default_nettype wire

//--- ddr3_odt_phase_gen.sv
// write and read windows must not overlap; odt_h is combinational from the start strobes
`timescale 1ns/100ps
`default_nettype none

module ddr3_odt_phase_gen
(
    input  wire                                    ctl_clk,
    input  wire                                    ctl_reset_n,
    input  wire ddr3_odt_timing_pkg::out_stage_t   cfg_output_regd,
    input  wire                                    write_start,
    input  wire                                    read_start,
    input  wire                                    write_active,
    input  wire                                    read_active,
    input  wire                                    diff_odd,
    output logic                                   odt_h,
    output logic                                   odt_l
);

    logic                         premux_h;
    logic                         read_h_q;
    logic                         read_active_q;
    logic                         odt_h_int;
    logic                         odt_l_q;
    ddr3_odt_cmd_pkg::odt_phase_t phase_d;
    ddr3_odt_cmd_pkg::odt_phase_t phase_r1_q;
    ddr3_odt_cmd_pkg::odt_phase_t phase_r2_q;
    ddr3_odt_cmd_pkg::odt_phase_t phase_sel;

    // high phase is on from the start cycle to the end of the window
    assign premux_h = write_start | read_start | write_active | read_active;

    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            read_h_q      <= 1'b0;
            read_active_q <= 1'b0;
            odt_l_q       <= 1'b0;
        end
        else
        begin
            // read only copy, one controller cycle late
            read_h_q      <= read_start | read_active;
            read_active_q <= read_active;
            // low phase trails the high phase by one memory clock pair
            odt_l_q       <= premux_h;
        end
    end

    // an odd gap pushes the read window half a cycle later, so the
    // high phase then takes the delayed copy for the whole window
    always_comb
    begin
        if (diff_odd && (read_start || read_active_q))
        begin
            odt_h_int = read_h_q;
        end
        else
        begin
            odt_h_int = premux_h;
        end
    end

    assign phase_d.odt_h = odt_h_int;
    assign phase_d.odt_l = odt_l_q;

    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            phase_r1_q <= '0;
            phase_r2_q <= '0;
        end
        else
        begin
            phase_r1_q <= phase_d;
            phase_r2_q <= phase_r1_q;
        end
    end

    always_comb
    begin
        case (cfg_output_regd)
            ddr3_odt_timing_pkg::OUT_REG1: phase_sel = phase_r1_q;
            ddr3_odt_timing_pkg::OUT_REG2: phase_sel = phase_r2_q;
            default:                       phase_sel = phase_d;
        endcase
    end

    assign odt_h = phase_sel.odt_h;
    assign odt_l = phase_sel.odt_l;

endmodule

`default_nettype wire

//--- ddr3_odt_window_counter.sv
// a start strobe inside an open window restarts it; burst type is taken at the start only
`timescale 1ns/100ps
`default_nettype none

`include "ddr3_odt_cfg.svh"

module ddr3_odt_window_counter
(
    input  wire                           ctl_clk,
    input  wire                           ctl_reset_n,
    input  wire                           start,
    input  wire ddr3_odt_cmd_pkg::burst_t chop,
    output logic                          active
);

    // last count of the window in controller clocks, start cycle not counted
    localparam ddr3_odt_timing_pkg::win_count_t LIMIT_BL8 =
        ddr3_odt_timing_pkg::win_count_t'(`ODT_HOLD_BL8 / (`ODT_DWIDTH_RATIO / 2) - 1);
    localparam ddr3_odt_timing_pkg::win_count_t LIMIT_BC4 =
        ddr3_odt_timing_pkg::win_count_t'(`ODT_HOLD_BC4 / (`ODT_DWIDTH_RATIO / 2) - 1);

    ddr3_odt_cmd_pkg::burst_t       burst_q;
    ddr3_odt_timing_pkg::win_count_t count_q;
    ddr3_odt_timing_pkg::win_count_t count_limit;

    assign count_limit = (burst_q == ddr3_odt_cmd_pkg::BURST_BC4) ? LIMIT_BC4 : LIMIT_BL8;
    assign active      = |count_q;

    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            burst_q <= ddr3_odt_cmd_pkg::BURST_BL8;
            count_q <= '0;
        end
        else if (start)
        begin
            burst_q <= chop;
            count_q <= ddr3_odt_timing_pkg::win_count_t'(1);
        end
        else if (count_q >= count_limit)
        begin
            count_q <= '0;
        end
        else if (count_q != '0)
        begin
            count_q <= count_q + ddr3_odt_timing_pkg::win_count_t'(1);
        end
    end

endmodule

`default_nettype wire

//--- ddr3_odt_read_align.sv
// assumes tcl >= cwl with a gap below 16; latency settings need 4 cycles to take effect
`timescale 1ns/100ps
`default_nettype none

`include "ddr3_odt_cfg.svh"

module ddr3_odt_read_align
(
    input  wire                             ctl_clk,
    input  wire                             ctl_reset_n,
    input  wire ddr3_odt_timing_pkg::lat_t  cfg_tcl,
    input  wire ddr3_odt_timing_pkg::lat_t  cfg_cas_wr_lat,
    input  wire                             bg_do_read,
    input  wire                             bg_do_burst_chop,
    output logic                            read_start,
    output ddr3_odt_cmd_pkg::burst_t        read_chop,
    output logic                            diff_odd
);

    // gaps below one controller clock need no delay line at all
    localparam int PIPE_THRESHOLD = `ODT_DWIDTH_RATIO / 2;

    ddr3_odt_timing_pkg::lat_t       diff_q;
    ddr3_odt_timing_pkg::lat_t       tap_next;
    ddr3_odt_timing_pkg::lat_t       tap_sel_q;
    logic                            gap_small_q;
    logic [`ODT_READ_PIPE_DEPTH-1:0] read_pipe_q;
    logic [`ODT_READ_PIPE_DEPTH-1:0] chop_pipe_q;

    // delay is gap/2 rounded up; tap 0 already holds one cycle of delay
    assign tap_next = (diff_q >> 1) + ddr3_odt_timing_pkg::lat_t'(diff_q[0])
                      - ddr3_odt_timing_pkg::lat_t'(1);

    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            diff_q      <= '0;
            diff_odd    <= 1'b0;
            gap_small_q <= 1'b0;
            tap_sel_q   <= '0;
        end
        else
        begin
            diff_q      <= cfg_tcl - cfg_cas_wr_lat;
            // odd number of memory clocks means a half controller cycle shift
            diff_odd    <= diff_q[0];
            gap_small_q <= (diff_q < ddr3_odt_timing_pkg::lat_t'(PIPE_THRESHOLD));
            if (diff_q < ddr3_odt_timing_pkg::lat_t'(PIPE_THRESHOLD))
            begin
                tap_sel_q <= '0;
            end
            else
            begin
                tap_sel_q <= tap_next;
            end
        end
    end

    // read strobe and its chop bit travel together down the delay line
    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            read_pipe_q <= '0;
            chop_pipe_q <= '0;
        end
        else
        begin
            read_pipe_q <= {read_pipe_q[`ODT_READ_PIPE_DEPTH-2:0], bg_do_read};
            chop_pipe_q <= {chop_pipe_q[`ODT_READ_PIPE_DEPTH-2:0], bg_do_burst_chop};
        end
    end

    always_comb
    begin
        if (gap_small_q)
        begin
            read_start = bg_do_read;
            read_chop  = ddr3_odt_cmd_pkg::burst_t'(bg_do_burst_chop);
        end
        else
        begin
            read_start = read_pipe_q[tap_sel_q];
            read_chop  = ddr3_odt_cmd_pkg::burst_t'(chop_pipe_q[tap_sel_q]);
        end
    end

endmodule

`default_nettype wire

//--- ddr3_odt_cmd_pkg.sv
// command side types; burst chop is carried as one bit beside the read or write strobe
`default_nettype none

package ddr3_odt_cmd_pkg;

    // burst type of the command that opened a window
    typedef enum logic
    {
        BURST_BL8 = 1'b0,
        BURST_BC4 = 1'b1
    } burst_t;

    // ODT level for the first and second memory clock of a controller clock
    typedef struct packed
    {
        logic odt_h;
        logic odt_l;
    } odt_phase_t;

endpackage

`default_nettype wire

//--- ddr3_odt_timing_pkg.sv
// latency fields assume tcl >= cwl; output stage values above OUT_REG2 act as direct
`default_nettype none

`include "ddr3_odt_cfg.svh"

package ddr3_odt_timing_pkg;

    // CAS latency or CAS write latency in memory clocks
    typedef logic [`ODT_LAT_WIDTH-1:0] lat_t;

    // position inside an open ODT window, in controller clocks
    typedef logic [3:0] win_count_t;

    // number of extra register stages on the ODT outputs
    typedef enum logic [1:0]
    {
        OUT_DIRECT = 2'd0,
        OUT_REG1   = 2'd1,
        OUT_REG2   = 2'd2
    } out_stage_t;

endpackage

`default_nettype wire

//--- ddr3_odt_cfg.svh
// half-rate controller only; hold lengths are in memory clocks and must be even
`ifndef DDR3_ODT_CFG_SVH
`define DDR3_ODT_CFG_SVH

// data words per controller clock, two memory clocks per controller clock
`define ODT_DWIDTH_RATIO 4

// ODT high time in memory clocks for a full BL8 burst
`define ODT_HOLD_BL8 6

// ODT high time in memory clocks for a chopped BC4 burst
`define ODT_HOLD_BC4 4

// width of the tcl and cwl configuration fields
`define ODT_LAT_WIDTH 4

// read strobe delay line, long enough for any gap that fits in ODT_LAT_WIDTH
`define ODT_READ_PIPE_DEPTH 16

`endif
